// ==== vlog.f ====
ecc_pkg.sv
ecc_encoder.sv
ecc_decoder.sv
ecc_85_top.sv
ecc_85_asserts.sv
tb_ecc_85.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the ecc testbench with verilator and run it, pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ecc_85 -f vlog.f -o tb_ecc_85_sim \
    && ./obj_dir/tb_ecc_85_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -qx 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_ecc_85.sv ====
`timescale 1ns/1ps

module tb_ecc_85;

    localparam int n_cycles = 3000;
    localparam int wait_max = 16;
    localparam int cw_w     = ecc_pkg::data_w + ecc_pkg::parity_w;

    typedef struct packed {
        ecc_pkg::data_t data;
        ecc_pkg::data_t mask;
        logic           sbit_err;
        logic           dbit_err;
    } expect_t;

    logic             clk;
    logic             reset;
    logic             in_valid;
    ecc_pkg::data_t   data_in;
    ecc_pkg::parity_t parity_in;
    logic             bypass;
    ecc_pkg::parity_t parity_out;
    logic             out_valid;
    ecc_pkg::data_t   data_out;
    ecc_pkg::data_t   mask;
    logic             sbit_err;
    logic             dbit_err;

    logic [31:0]      lcg_state;
    int               hpos [ecc_pkg::data_w];    // model hamming positions
    expect_t          exp_q [$];                 // at most one entry
    expect_t          staged;                    // result of the word on the pins
    logic             staged_valid;
    ecc_pkg::data_t   staged_raw;
    expect_t          last_out;                  // what the registers hold
    int               kind_cnt [4];
    int               bypass_cnt;

    ecc_85_top ecc_85_top_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .parity_out (parity_out),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #10 clk = ~clk;

    // ==================================================
    // random numbers
    // ==================================================

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'({8'd0, r[31:8]}) % n;    // upper bits of the state
    endfunction

    function automatic ecc_pkg::data_t rand_data();
        logic [95:0] r;
        r = {next_rand(), next_rand(), next_rand()};
        return r[ecc_pkg::data_w-1:0];
    endfunction

    // ==================================================
    // reference model
    // ==================================================

    // positions 3 and up that are not powers of two
    task automatic build_positions();
        int n;
        n = 0;
        for (int p = 3; p < 128 && n < ecc_pkg::data_w; p++) begin
            if ($countones(p) != 1) begin
                hpos[n] = p;
                n++;
            end
        end
    endtask

    function automatic ecc_pkg::parity_t model_parity(input ecc_pkg::data_t d);
        ecc_pkg::parity_t par;
        par = '0;
        for (int i = 0; i < ecc_pkg::data_w; i++) begin
            for (int k = 0; k < 7; k++) begin
                if (hpos[i][k]) begin
                    par[k] = par[k] ^ d[i];
                end
            end
            if ($countones(hpos[i]) % 2 == 0) begin
                par[7] = par[7] ^ d[i];    // overall bit over even weight positions
            end
        end
        return par;
    endfunction

    // ==================================================
    // checking
    // ==================================================

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        assert (got === want) else begin
            $display("MISMATCH %s: got %0h expected %0h", name, got, want);
            stop_run();
        end
    endtask

    // called at the falling edge when inputs and registers have settled
    task automatic cycle_checks();
        expect_t e;
        check_value("parity_out", parity_out, model_parity(staged_raw));
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_value("out_valid", out_valid, 1'b1);
            last_out = e;
        end else begin
            check_value("out_valid", out_valid, 1'b0);
            e = last_out;    // outputs hold
        end
        check_value("data_out", data_out, e.data);
        check_value("mask", mask, e.mask);
        check_value("sbit_err", sbit_err, e.sbit_err);
        check_value("dbit_err", dbit_err, e.dbit_err);
        if (staged_valid) begin
            exp_q.push_back(staged);
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================

    // kind 0 clean, 1 data bit, 2 check bit, 3 two bits of the codeword
    task automatic drive_item(input int kind, input logic byp, input logic valid);
        ecc_pkg::data_t   orig;
        ecc_pkg::data_t   dat;
        ecc_pkg::parity_t par;
        logic [cw_w-1:0]  cw;
        expect_t          e;
        int               a;
        int               b;
        orig = rand_data();
        par  = model_parity(orig);
        dat  = orig;
        e    = '0;
        case (kind)
            1: begin
                a          = rand_below(ecc_pkg::data_w);
                dat[a]     = ~dat[a];
                e.mask[a]  = 1'b1;
                e.sbit_err = 1'b1;
            end
            2: begin
                a          = rand_below(ecc_pkg::parity_w);
                par[a]     = ~par[a];
                e.sbit_err = 1'b1;
            end
            3: begin
                a = rand_below(cw_w);
                b = rand_below(cw_w - 1);
                if (b >= a) begin
                    b++;    // keep the two bits distinct
                end
                cw         = {dat, par};
                cw[a]      = ~cw[a];
                cw[b]      = ~cw[b];
                {dat, par} = cw;
                e.dbit_err = 1'b1;
            end
            default: begin
            end
        endcase
        if (byp) begin
            e.data     = dat;    // mask still decoded
            e.sbit_err = 1'b0;
            e.dbit_err = 1'b0;
        end else if (kind == 1) begin
            e.data = orig;
        end else begin
            e.data = dat;
        end
        if (valid && byp) begin
            bypass_cnt++;
        end else if (valid) begin
            kind_cnt[kind]++;
        end
        in_valid     <= valid;
        data_in      <= dat;
        parity_in    <= par;
        bypass       <= byp;
        staged       = e;
        staged_valid = valid;
        staged_raw   = dat;
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        int   wait_cnt;
        int   kind;
        logic byp;
        logic valid;
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        data_in      = '0;
        parity_in    = '0;
        bypass       = 1'b0;
        lcg_state    = 32'd24;
        staged       = '0;
        staged_valid = 1'b0;
        staged_raw   = '0;
        last_out     = '0;    // reset data register and clear syndrome
        bypass_cnt   = 0;
        for (int i = 0; i < 4; i++) begin
            kind_cnt[i] = 0;
        end
        build_positions();

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        @(negedge clk);
        cycle_checks();

        // first word and the wait for it to come out
        @(posedge clk);
        drive_item(0, 1'b0, 1'b1);
        @(negedge clk);
        cycle_checks();
        @(posedge clk);
        in_valid     <= 1'b0;
        staged_valid = 1'b0;
        wait_cnt     = 0;
        @(negedge clk);
        while (!out_valid) begin
            wait_cnt++;
            assert (wait_cnt < wait_max) else begin
                $display("timeout while waiting for the first out_valid after reset");
                stop_run();
            end
            @(negedge clk);
        end
        cycle_checks();

        for (int c = 0; c < n_cycles; c++) begin
            @(posedge clk);
            kind  = rand_below(4);
            byp   = (rand_below(5) == 0);
            valid = (rand_below(4) != 0);    // about three in four
            drive_item(kind, byp, valid);
            @(negedge clk);
            cycle_checks();
        end

        // drain the last word
        @(posedge clk);
        in_valid     <= 1'b0;
        staged_valid = 1'b0;
        @(negedge clk);
        cycle_checks();

        for (int i = 0; i < 4; i++) begin
            assert (kind_cnt[i] > 0) else begin
                $display("error kind %0d was never sent without bypass", i);
                stop_run();
            end
        end
        assert (bypass_cnt > 0) else begin
            $display("no word was sent with bypass high");
            stop_run();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== ecc_85_asserts.sv ====
`timescale 1ns/1ps

module ecc_85_asserts (
    input logic           clk,
    input logic           reset,
    input logic           in_valid,
    input logic           out_valid,
    input ecc_pkg::data_t mask,
    input logic           sbit_err,
    input logic           dbit_err
);

    // ==================================================
    // status and mask shape
    // ==================================================

    property flags_exclusive;
        @(posedge clk) disable iff (reset)
        !(sbit_err && dbit_err);
    endproperty

    property mask_onehot0;
        @(posedge clk) disable iff (reset)
        $onehot0(mask);    // at most one bit corrected
    endproperty

    // ==================================================
    // strobe timing
    // ==================================================

    property valid_follows;
        @(posedge clk)
        !reset |=> (out_valid == $past(in_valid));
    endproperty

    property valid_low_after_reset;
        @(posedge clk)
        reset |=> !out_valid;
    endproperty

    flags_exclusive_a : assert property (flags_exclusive)
        else $error("sbit_err and dbit_err both high");
    mask_onehot0_a : assert property (mask_onehot0)
        else $error("mask has more than one bit set");
    valid_follows_a : assert property (valid_follows)
        else $error("out_valid does not follow in_valid by one cycle");
    valid_low_after_reset_a : assert property (valid_low_after_reset)
        else $error("out_valid high in the cycle after reset");

endmodule

bind ecc_85_top ecc_85_asserts ecc_85_asserts_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .mask      (mask),
    .sbit_err  (sbit_err),
    .dbit_err  (dbit_err)
);

// ==== ecc_85_top.sv ====
`timescale 1ns/1ps

module ecc_85_top (
    input  logic             clk,
    input  logic             reset,

    // encode side and raw word
    input  logic             in_valid,
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::parity_t parity_out,

    // corrected word, one cycle later
    output logic             out_valid,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::data_t   mask,
    output logic             sbit_err,
    output logic             dbit_err
);

    ecc_pkg::parity_t    calc_parity;
    ecc_pkg::ecc_word_t  dec_word;
    ecc_pkg::ecc_status_t dec_status;

    // ==================================================
    // encoder
    // ==================================================

    ecc_encoder ecc_encoder_i (
        .data   (data_in),
        .parity (calc_parity)
    );

    assign parity_out = calc_parity;    // same cycle as data_in

    // ==================================================
    // syndrome stage and corrector
    // ==================================================

    assign dec_word.data   = data_in;
    assign dec_word.parity = parity_in;

    ecc_decoder ecc_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .word        (dec_word),
        .calc_parity (calc_parity),
        .bypass      (bypass),
        .out_valid   (out_valid),
        .data_out    (data_out),
        .mask        (mask),
        .status      (dec_status)
    );

    assign sbit_err = dec_status.sbit_err;
    assign dbit_err = dec_status.dbit_err;

endmodule

// ==== ecc_decoder.sv ====
`timescale 1ns/1ps

module ecc_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  ecc_pkg::ecc_word_t  word,
    input  ecc_pkg::parity_t    calc_parity,
    input  logic                bypass,
    output logic                out_valid,
    output ecc_pkg::data_t      data_out,
    output ecc_pkg::data_t      mask,
    output ecc_pkg::ecc_status_t status
);

    ecc_pkg::parity_t syndrome;
    ecc_pkg::parity_t syn_q;
    ecc_pkg::data_t   data_q;
    logic             bypass_q;

    logic             syn_zero;
    logic             chk_err;     // lone check bit flipped
    logic             data_err;    // syndrome matches a data column
    logic             dbl_err;

    assign syndrome = word.parity ^ calc_parity;

    // ==================================================
    // syndrome register stage
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            syn_q     <= '0;
            data_q    <= '0;
            bypass_q  <= 1'b0;
        end else begin
            out_valid <= in_valid;    // fixed one cycle latency
            if (in_valid) begin
                syn_q    <= syndrome;
                data_q   <= word.data;
                bypass_q <= bypass;
            end
        end
    end

    // ==================================================
    // syndrome decode
    // ==================================================

    // one compare per data bit against its column
    always_comb begin
        logic [ecc_pkg::pos_w-1:0] pos;
        ecc_pkg::parity_t          col;
        mask = '0;
        pos  = '0;
        col  = '0;
        for (int i = 0; i < ecc_pkg::data_w; i++) begin
            pos     = ecc_pkg::data_pos(i);
            col     = {ecc_pkg::even_weight(pos), pos};
            mask[i] = (syn_q == col);
        end
    end

    // data columns carry at least three ones, so these never overlap
    assign syn_zero = (syn_q == '0);
    assign chk_err  = !syn_zero && ((syn_q & (syn_q - 1'b1)) == '0);
    assign data_err = |mask;
    assign dbl_err  = !syn_zero && !chk_err && !data_err;

    // ==================================================
    // correction and flags
    // ==================================================

    assign data_out = bypass_q ? data_q : (data_q ^ mask);    // mask still shown

    always_comb begin
        status          = '0;
        status.sbit_err = !bypass_q && (chk_err || data_err);
        status.dbit_err = !bypass_q && dbl_err;
    end

endmodule

// ==== ecc_encoder.sv ====
`timescale 1ns/1ps

module ecc_encoder (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t parity
);

    // ==================================================
    // check bit generation
    // ==================================================

    // each set data bit folds its syndrome column into the check bits
    // with the columns taken from the package rule
    always_comb begin
        logic [ecc_pkg::pos_w-1:0] pos;
        ecc_pkg::parity_t          col;
        parity = '0;
        pos    = '0;
        col    = '0;
        for (int i = 0; i < ecc_pkg::data_w; i++) begin
            pos = ecc_pkg::data_pos(i);
            col = {ecc_pkg::even_weight(pos), pos};    // bit 7 = overall
            if (data[i]) begin
                parity = parity ^ col;
            end
        end
    end

endmodule

// ==== ecc_pkg.sv ====
package ecc_pkg;

    // ==================================================
    // code geometry
    // ==================================================

    localparam int data_w   = 85;
    localparam int parity_w = 8;
    localparam int pos_w    = 7;    // hamming position 3 to 127

    typedef logic [data_w-1:0]   data_t;
    typedef logic [parity_w-1:0] parity_t;    // check bits or syndrome

    // ==================================================
    // bus structs
    // ==================================================

    typedef struct packed {
        data_t   data;
        parity_t parity;
    } ecc_word_t;

    typedef struct packed {
        logic sbit_err;    // corrected data or check bit error
        logic dbit_err;    // uncorrectable
    } ecc_status_t;

    // ==================================================
    // position rule
    // ==================================================

    // data bit idx sits on the idx-th position from 3 up that is
    // not a power of two as those hold the check bits
    function automatic logic [pos_w-1:0] data_pos(input int idx);
        logic [pos_w-1:0] res;
        int               cnt;
        res = '0;
        cnt = 0;
        for (int p = 3; p < (1 << pos_w); p++) begin
            if ((p & (p - 1)) != 0) begin    // skip check positions
                if (cnt == idx) begin
                    res = p[pos_w-1:0];
                end
                cnt++;
            end
        end
        return res;
    endfunction

    // overall parity bit covers the even weight positions
    function automatic logic even_weight(input logic [pos_w-1:0] pos);
        return ~^pos;
    endfunction

endpackage
